/* Bender.yml */
package:
  name: bexkat_core

sources:
  - bexkat_isa_pkg.sv
  - bexkat_pipe_pkg.sv
  - register_file.sv
  - instr_decode.sv
  - alu_execute.sv
  - bexkat_core_top.sv
  - target: test
    files:
      - bexkat_core_tb.sv

export_include_dirs: []

dependencies: {}

/* alu_execute.sv */
`timescale 1ns/10ps

module alu_execute (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [63:0]                  ir_i,
  input  logic [31:0]                  pc_i,
  input  logic [31:0]                  reg_data1_i,
  input  logic [31:0]                  reg_data2_i,
  input  logic [1:0]                   reg_write_i,
  output logic [1:0]                   wb_write_o,
  output logic [3:0]                   wb_addr_o,
  output logic [31:0]                  wb_data_o,
  output logic [31:0]                  wb_pc_o,
  output logic [bexkat_pipe_pkg::CC_C:0] ccr_o
);

  import bexkat_isa_pkg::*;
  import bexkat_pipe_pkg::*;

  ir_word_t    ir_word;
  logic [3:0]  itype;
  logic [3:0]  alu_op;
  logic [31:0] imm_ext;
  logic [31:0] alu_b;
  logic [31:0] alu_out;
  logic [31:0] result;
  logic [31:0] cmp_diff;
  logic        cmp_borrow;
  logic [CC_C:0] ccr_next;

  function automatic logic [31:0] alu_calc(input logic [3:0]  op,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
    logic [31:0] res;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SHL:  res = a << b[4:0];
      OP_SHR:  res = a >> b[4:0];
      default: res = 32'h0; // Unassigned op codes give zero
    endcase
    return res;
  endfunction

  assign ir_word = ir_i[31:0];
  assign itype   = ir_word.reg_form.itype;
  assign alu_op  = ir_word.reg_form.op;

  // The immediate form reads its constant from its own view
  assign imm_ext = {{16{ir_word.imm_form.imm[15]}}, ir_word.imm_form.imm};
  assign alu_b   = (itype == T_ALUI) ? imm_ext : reg_data2_i;
  assign alu_out = alu_calc(alu_op, reg_data1_i, alu_b);

  // Borrow out of the 33-bit subtract is the unsigned less-than
  assign {cmp_borrow, cmp_diff} = {1'b0, reg_data1_i} - {1'b0, reg_data2_i};

  always_comb
  begin
    case (itype)
      T_ALU, T_ALUI: result = alu_out;
      T_MOV:         result = reg_data1_i; // Width is applied at the register file
      T_LDI:         result = ir_i[IR_LONG_LSB +: 32];
      default:       result = 32'h0;
    endcase
  end

  always_comb
  begin
    ccr_next = ccr_o;
    if (itype == T_CMP)
    begin
      ccr_next[CC_Z] = (reg_data1_i == reg_data2_i);
      ccr_next[CC_N] = cmp_diff[31];
      ccr_next[CC_C] = cmp_borrow;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      wb_write_o <= WR_NONE;
      wb_addr_o  <= 4'h0;
      wb_data_o  <= 32'h0;
      wb_pc_o    <= 32'h0;
      ccr_o      <= '0;
    end
    else
    begin
      wb_write_o <= reg_write_i;
      wb_addr_o  <= ir_word.reg_form.ra; // Destination is always ra
      wb_data_o  <= result;
      wb_pc_o    <= pc_i;
      ccr_o      <= ccr_next;
    end
  end

endmodule

/* bexkat_core.f */
bexkat_isa_pkg.sv
bexkat_pipe_pkg.sv
register_file.sv
instr_decode.sv
alu_execute.sv
bexkat_core_top.sv
bexkat_core_tb.sv

/* bexkat_core_tb.sv */
`timescale 1ns/10ps

module bexkat_core_tb;

  import bexkat_isa_pkg::*;
  import bexkat_pipe_pkg::*;

  localparam int RANDOM_COUNT = 300;
  localparam int DRAIN_LIMIT  = 10;

  logic          clk_i = 1'b0;
  logic          rst_i = 1'b1;
  logic [63:0]   ir_i  = 64'h0;
  logic [31:0]   pc_i  = 32'h0;
  logic [1:0]    wb_write_o;
  logic [3:0]    wb_addr_o;
  logic [31:0]   wb_data_o;
  logic [31:0]   wb_pc_o;
  logic [CC_C:0] ccr_o;

  // Reference model, advanced in program order as instructions are issued
  logic [31:0]   model_regs [NUM_REGS];
  logic [CC_C:0] model_ccr;
  logic [31:0]   next_pc;
  logic [3:0]    last_dest;
  logic          last_wrote;

  logic [72:0]   pending [$]; // {write, addr, data, pc, ccr} per issued instruction
  logic          chk_valid  = 1'b0;
  logic          rst_window = 1'b0;
  logic [1:0]    exp_write;
  logic [3:0]    exp_addr;
  logic [31:0]   exp_data;
  logic [31:0]   exp_pc;
  logic [CC_C:0] exp_ccr;
  int            n_pushed;
  int            n_popped;
  int            reset_errs;
  int            wb_errs;
  int            ccr_errs;
  int            timeout_errs;

  bexkat_core_top u_bexkat_core_top (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .ir_i       (ir_i),
    .pc_i       (pc_i),
    .wb_write_o (wb_write_o),
    .wb_addr_o  (wb_addr_o),
    .wb_data_o  (wb_data_o),
    .wb_pc_o    (wb_pc_o),
    .ccr_o      (ccr_o)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] alu_result(input logic [3:0]  op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] res;
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      OP_SHL:  res = a << b[4:0];
      OP_SHR:  res = a >> b[4:0];
      default: res = 32'h0;
    endcase
    return res;
  endfunction

  function automatic logic [31:0] merged_value(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [1:0]  width);
    logic [31:0] res;
    case (width)
      WR_BYTE: res = {old_val[31:8], new_val[7:0]};
      WR_HALF: res = {old_val[31:16], new_val[15:0]};
      WR_WORD: res = new_val;
      default: res = old_val;
    endcase
    return res;
  endfunction

  function automatic logic [63:0] encode_instr(input logic [31:0] hi, input logic [3:0] itype,
                                               input logic [3:0] op, input logic [3:0] ra,
                                               input logic [3:0] rb, input logic [15:0] low);
    return {hi, itype, op, ra, rb, low};
  endfunction

  // Source registers per type, as the execute rules use them
  function automatic logic reads_reg(input logic [63:0] instr, input logic [3:0] r);
    case (instr[31:28])
      T_CMP:         return (instr[23:20] == r) || (instr[19:16] == r);
      T_ALU:         return (instr[19:16] == r) || (instr[15:12] == r);
      T_ALUI, T_MOV: return (instr[19:16] == r);
      default:       return 1'b0;
    endcase
  endfunction

  function automatic logic [63:0] random_instr();
    logic [3:0] itype;
    logic [3:0] op;
    case ($urandom_range(0, 9))
      0:       itype = T_NOP;
      1, 2:    itype = T_CMP;
      3, 4:    itype = T_MOV;
      5, 6:    itype = T_ALU;
      7, 8:    itype = T_ALUI;
      default: itype = T_LDI;
    endcase
    // Ops 7 and 8 are undefined and must give zero
    op = (itype == T_MOV) ? 4'($urandom_range(0, 3)) : 4'($urandom_range(0, 8));
    return encode_instr($urandom, itype, op, 4'($urandom_range(0, 15)),
                        4'($urandom_range(0, 15)), 16'($urandom));
  endfunction

  task automatic issue_instr(input logic [63:0] instr);
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [31:0] res;
    logic [31:0] diff;
    logic [1:0]  width;
    logic [72:0] entry;
    op    = instr[27:24];
    ra    = instr[23:20];
    rb    = instr[19:16];
    rc    = instr[15:12];
    res   = 32'h0;
    width = WR_NONE;
    case (instr[31:28])
      T_ALU:
      begin
        res   = alu_result(op, model_regs[rb], model_regs[rc]);
        width = WR_WORD;
      end
      T_ALUI:
      begin
        res   = alu_result(op, model_regs[rb], {{16{instr[15]}}, instr[15:0]});
        width = WR_WORD;
      end
      T_MOV:
      begin
        res   = model_regs[rb]; // The trace shows the full word and the width cuts it at write-back
        width = op[1:0];
      end
      T_LDI:
      begin
        res   = instr[63:32];
        width = WR_WORD;
      end
      T_CMP:
      begin
        diff = model_regs[ra] - model_regs[rb];
        model_ccr[CC_Z] = (model_regs[ra] == model_regs[rb]);
        model_ccr[CC_N] = diff[31];
        model_ccr[CC_C] = (model_regs[ra] < model_regs[rb]);
      end
      default:
      begin
      end
    endcase
    model_regs[ra] = merged_value(model_regs[ra], res, width);
    last_dest  = ra;
    last_wrote = (width != WR_NONE);

    @(posedge clk_i);
    ir_i       <= instr;
    pc_i       <= next_pc;
    rst_window <= 1'b0;
    // The entry issued two edges ago is now on the wb outputs
    if (pending.size() == 2)
    begin
      entry = pending.pop_front();
      {exp_write, exp_addr, exp_data, exp_pc, exp_ccr} <= entry;
      chk_valid <= 1'b1;
      n_popped++;
    end
    pending.push_back({width, ra, res, next_pc, model_ccr});
    n_pushed++;
    next_pc = next_pc + 32'h8;
  endtask

  // No forwarding in the core, so a consumer right after its producer gets a NOP first
  task automatic issue_safe(input logic [63:0] instr);
    if (last_wrote && reads_reg(instr, last_dest))
    begin
      issue_instr(64'h0);
    end
    issue_instr(instr);
  endtask

  check_reset_write: assert property (@(posedge clk_i) rst_window |-> wb_write_o == WR_NONE)
    else begin
      reset_errs++;
      $display("[ERROR] wb_write_o got %h expected %h", $sampled(wb_write_o), WR_NONE);
    end
  check_reset_ccr: assert property (@(posedge clk_i) rst_window |-> ccr_o == '0)
    else begin
      reset_errs++;
      $display("[ERROR] ccr_o got %h expected 0", $sampled(ccr_o));
    end
  check_write: assert property (@(posedge clk_i) chk_valid |-> wb_write_o == exp_write)
    else begin
      wb_errs++;
      $display("[ERROR] wb_write_o got %h expected %h", $sampled(wb_write_o), $sampled(exp_write));
    end
  check_addr: assert property (@(posedge clk_i)
                               (chk_valid && exp_write != WR_NONE) |-> wb_addr_o == exp_addr)
    else begin
      wb_errs++;
      $display("[ERROR] wb_addr_o got %h expected %h", $sampled(wb_addr_o), $sampled(exp_addr));
    end
  check_data: assert property (@(posedge clk_i)
                               (chk_valid && exp_write != WR_NONE) |-> wb_data_o == exp_data)
    else begin
      wb_errs++;
      $display("[ERROR] wb_data_o got %h expected %h", $sampled(wb_data_o), $sampled(exp_data));
    end
  check_pc: assert property (@(posedge clk_i) chk_valid |-> wb_pc_o == exp_pc)
    else begin
      wb_errs++;
      $display("[ERROR] wb_pc_o got %h expected %h", $sampled(wb_pc_o), $sampled(exp_pc));
    end
  check_ccr: assert property (@(posedge clk_i) chk_valid |-> ccr_o == exp_ccr)
    else begin
      ccr_errs++;
      $display("[ERROR] ccr_o got %h expected %h", $sampled(ccr_o), $sampled(exp_ccr));
    end

  initial
  begin
    int target;
    int wait_cnt;
    void'($urandom(64));
    for (int i = 0; i < NUM_REGS; i++)
    begin
      model_regs[i] = 32'h0;
    end
    model_ccr  = '0;
    next_pc    = 32'h100;
    last_dest  = 4'h0;
    last_wrote = 1'b0;

    for (int i = 0; i < 8; i++)
    begin
      @(posedge clk_i);
      rst_window <= 1'b1;
    end
    rst_i <= 1'b0;
    @(posedge clk_i); // First cycle out of reset still shows cleared outputs

    for (int r = 0; r < NUM_REGS; r++)
    begin
      issue_safe(encode_instr($urandom, T_LDI, 4'h0, 4'(r), 4'h0, 16'h0));
    end

    // Byte move into r1, then copy r1 whole to see the kept upper bits
    issue_safe(encode_instr(32'hA5A5_A5A5, T_LDI, 4'h0, 4'd1, 4'd0, 16'h0));
    issue_safe(encode_instr(32'h1234_5678, T_LDI, 4'h0, 4'd2, 4'd0, 16'h0));
    issue_safe(encode_instr(32'h0, T_MOV, {2'b00, WR_BYTE}, 4'd1, 4'd2, 16'h0));
    issue_safe(encode_instr(32'h0, T_MOV, {2'b00, WR_WORD}, 4'd3, 4'd1, 16'h0));
    issue_safe(encode_instr(32'h0, T_MOV, {2'b00, WR_HALF}, 4'd4, 4'd2, 16'h0));
    issue_safe(encode_instr(32'h0, T_CMP, 4'h0, 4'd3, 4'd3, 16'h0));
    issue_safe(encode_instr(32'h0, T_ALUI, OP_ADD, 4'd5, 4'd2, 16'hFFF0));
    issue_safe(encode_instr(32'h0, T_ALU, 4'hF, 4'd6, 4'd1, 16'h2000));

    for (int i = 0; i < RANDOM_COUNT; i++)
    begin
      issue_safe(random_instr());
    end

    target   = n_pushed;
    wait_cnt = 0;
    while (n_popped < target && wait_cnt < DRAIN_LIMIT)
    begin
      issue_instr(64'h0);
      wait_cnt++;
    end
    if (n_popped < target)
    begin
      timeout_errs++;
      $display("Timeout: pipeline did not drain, %0d of %0d results checked", n_popped, target);
    end
    @(posedge clk_i);
    chk_valid <= 1'b0;
    @(negedge clk_i);

    $display("Errors: reset %0d, writeback %0d, ccr %0d, timeout %0d",
             reset_errs, wb_errs, ccr_errs, timeout_errs);
    if (reset_errs + wb_errs + ccr_errs + timeout_errs == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* bexkat_core_top.sv */
`timescale 1ns/10ps

module bexkat_core_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [63:0]                  ir_i,
  input  logic [31:0]                  pc_i,
  output logic [1:0]                   wb_write_o,
  output logic [3:0]                   wb_addr_o,
  output logic [31:0]                  wb_data_o,
  output logic [31:0]                  wb_pc_o,
  output logic [bexkat_pipe_pkg::CC_C:0] ccr_o
);

  logic [1:0]  dec_write;
  logic [63:0] dec_ir;
  logic [31:0] dec_pc;
  logic [31:0] dec_data1;
  logic [31:0] dec_data2;

  // Write-back loops from execute into the register file inside decode
  instr_decode u_instr_decode (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .ir_i             (ir_i),
    .pc_i             (pc_i),
    .reg_write_i      (wb_write_o),
    .reg_write_addr_i (wb_addr_o),
    .reg_data_i       (wb_data_o),
    .reg_write_o      (dec_write),
    .ir_o             (dec_ir),
    .pc_o             (dec_pc),
    .reg_data1_o      (dec_data1),
    .reg_data2_o      (dec_data2)
  );

  alu_execute u_alu_execute (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ir_i        (dec_ir),
    .pc_i        (dec_pc),
    .reg_data1_i (dec_data1),
    .reg_data2_i (dec_data2),
    .reg_write_i (dec_write),
    .wb_write_o  (wb_write_o),
    .wb_addr_o   (wb_addr_o),
    .wb_data_o   (wb_data_o),
    .wb_pc_o     (wb_pc_o),
    .ccr_o       (ccr_o)
  );

endmodule

/* bexkat_isa_pkg.sv */
package bexkat_isa_pkg;

  // Instruction types, found in bits 31:28 of the low word
  localparam logic [3:0] T_NOP  = 4'h0;
  localparam logic [3:0] T_CMP  = 4'h1;
  localparam logic [3:0] T_MOV  = 4'h2;
  localparam logic [3:0] T_ALU  = 4'h3;
  localparam logic [3:0] T_ALUI = 4'h4;
  localparam logic [3:0] T_LDI  = 4'h5;

  // ALU operations for both the register and the immediate form
  localparam logic [3:0] OP_ADD = 4'h0;
  localparam logic [3:0] OP_SUB = 4'h1;
  localparam logic [3:0] OP_AND = 4'h2;
  localparam logic [3:0] OP_OR  = 4'h3;
  localparam logic [3:0] OP_XOR = 4'h4;
  localparam logic [3:0] OP_SHL = 4'h5;
  localparam logic [3:0] OP_SHR = 4'h6; // Logical shift, zero fill

  // Three register fields, used by ALU, MOV, CMP
  typedef struct packed {
    logic [3:0]  itype;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  rc;
    logic [11:0] spare;
  } reg_form_t;

  // Two registers and a short immediate, used by ALUI
  typedef struct packed {
    logic [3:0]  itype;
    logic [3:0]  op;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [15:0] imm; // Two's complement, sign extended in execute
  } imm_form_t;

  // The low instruction word read either way
  typedef union packed {
    reg_form_t reg_form;
    imm_form_t imm_form;
  } ir_word_t;

  // LDI carries its whole 32-bit constant in the high word
  localparam int IR_LONG_LSB = 32;

endpackage

/* bexkat_pipe_pkg.sv */
package bexkat_pipe_pkg;

  // Width of a register write, carried along with each instruction
  localparam logic [1:0] WR_NONE = 2'h0;
  localparam logic [1:0] WR_BYTE = 2'h1; // Bits 7:0 only
  localparam logic [1:0] WR_HALF = 2'h2; // Bits 15:0 only
  localparam logic [1:0] WR_WORD = 2'h3;

  // Bit positions inside the condition code register
  localparam int CC_Z = 0;
  localparam int CC_N = 1;
  localparam int CC_C = 2;

  // Register file sizing, tied to the 4-bit register fields
  localparam int NUM_REGS   = 16;
  localparam int REG_ADDR_W = 4;

endpackage

/* instr_decode.sv */
`timescale 1ns/10ps

module instr_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [63:0]                          ir_i,
  input  logic [31:0]                          pc_i,
  input  logic [1:0]                           reg_write_i,
  input  logic [bexkat_pipe_pkg::REG_ADDR_W-1:0] reg_write_addr_i,
  input  logic [31:0]                          reg_data_i,
  output logic [1:0]                           reg_write_o,
  output logic [63:0]                          ir_o,
  output logic [31:0]                          pc_o,
  output logic [31:0]                          reg_data1_o,
  output logic [31:0]                          reg_data2_o
);

  import bexkat_isa_pkg::*;
  import bexkat_pipe_pkg::*;

  ir_word_t              ir_word;
  logic [REG_ADDR_W-1:0] rd_addr1;
  logic [REG_ADDR_W-1:0] rd_addr2;
  logic [31:0]           rf_data1;
  logic [31:0]           rf_data2;
  logic [1:0]            reg_write_next;

  assign ir_word = ir_i[31:0];

  // CMP compares ra with rb; every other type sources rb and rc
  assign rd_addr1 = (ir_word.reg_form.itype == T_CMP) ? ir_word.reg_form.ra
                                                      : ir_word.reg_form.rb;
  assign rd_addr2 = (ir_word.reg_form.itype == T_CMP) ? ir_word.reg_form.rb
                                                      : ir_word.reg_form.rc;

  always_comb
  begin
    case (ir_word.reg_form.itype)
      T_ALU, T_ALUI, T_LDI: reg_write_next = WR_WORD;
      T_MOV:                reg_write_next = ir_word.reg_form.op[1:0]; // Op selects the width
      default:              reg_write_next = WR_NONE;
    endcase
  end

  register_file u_register_file (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .wr_addr_i  (reg_write_addr_i),
    .wr_data_i  (reg_data_i),
    .wr_width_i (reg_write_i),
    .rd_data1_o (rf_data1),
    .rd_data2_o (rf_data2)
  );

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      reg_write_o <= WR_NONE;
      ir_o        <= 64'h0;
      pc_o        <= 32'h0;
      reg_data1_o <= 32'h0;
      reg_data2_o <= 32'h0;
    end
    else
    begin
      reg_write_o <= reg_write_next;
      ir_o        <= ir_i;
      pc_o        <= pc_i;
      reg_data1_o <= rf_data1;
      reg_data2_o <= rf_data2;
    end
  end

endmodule

/* register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [bexkat_pipe_pkg::REG_ADDR_W-1:0] rd_addr1_i,
  input  logic [bexkat_pipe_pkg::REG_ADDR_W-1:0] rd_addr2_i,
  input  logic [bexkat_pipe_pkg::REG_ADDR_W-1:0] wr_addr_i,
  input  logic [31:0]                          wr_data_i,
  input  logic [1:0]                           wr_width_i,
  output logic [31:0]                          rd_data1_o,
  output logic [31:0]                          rd_data2_o
);

  import bexkat_pipe_pkg::*;

  logic [31:0] regs [NUM_REGS];
  logic [31:0] wr_merged;
  logic        wr_active;

  // Lay the new data over the old value, keeping bits above the width
  function automatic logic [31:0] merge_write(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [1:0]  width);
    logic [31:0] result;
    result = old_val;
    case (width)
      WR_BYTE: result[7:0] = new_val[7:0];
      WR_HALF: result[15:0] = new_val[15:0];
      WR_WORD: result = new_val;
      default: result = old_val;
    endcase
    return result;
  endfunction

  assign wr_active = (wr_width_i != WR_NONE);
  assign wr_merged = merge_write(regs[wr_addr_i], wr_data_i, wr_width_i);

  // A read of the register being written sees the value it is about to hold
  assign rd_data1_o = (wr_active && rd_addr1_i == wr_addr_i) ? wr_merged : regs[rd_addr1_i];
  assign rd_data2_o = (wr_active && rd_addr2_i == wr_addr_i) ? wr_merged : regs[rd_addr2_i];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= 32'h0;
      end
    end
    else if (wr_active)
    begin
      regs[wr_addr_i] <= wr_merged;
    end
  end

endmodule
